/* rtl/vga_pkg.sv */
`default_nettype none

package vga_pkg;

	// Byte address on the memory read port
	localparam int ADDR_WIDTH = 32;

	// One framebuffer pixel per memory data word
	localparam int MEM_DATA_WIDTH = 32;

	// Width of one colour channel on the DAC
	localparam int COLOR_WIDTH = 8;

	// Address step from one pixel to the next
	localparam int BYTES_PER_PIXEL = MEM_DATA_WIDTH / 8;

	// Pixel word as it sits in the FIFO
	// Memory side sees the raw word, DAC side picks out the channels
	typedef union packed
	{
		logic [MEM_DATA_WIDTH-1:0] raw;

		// Most significant byte first
		struct packed
		{
			logic [COLOR_WIDTH-1:0] r;
			logic [COLOR_WIDTH-1:0] g;
			logic [COLOR_WIDTH-1:0] b;
			// Not shown on the display
			logic [COLOR_WIDTH-1:0] alpha;
		} color;
	} pixel_word_t;

endpackage

`default_nettype wire

/* rtl/vga_timing_generator.sv */
`timescale 1ns/10ps
`default_nettype none

module vga_timing_generator
#(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT = 16,
	parameter int H_SYNC = 96,
	parameter int H_BACK = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT = 10,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 33
)
(
	input wire clk,
	input wire reset,
	output logic pixel_enable,
	output logic in_visible_region,
	output logic new_frame,
	output logic vga_hs,
	output logic vga_vs
);

	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int H_WIDTH = $clog2(H_TOTAL);
	localparam int V_WIDTH = $clog2(V_TOTAL);

	// Phase boundaries, as last index of each region
	localparam logic [H_WIDTH-1:0] H_LAST_ACTIVE = H_WIDTH'(H_ACTIVE - 1);
	localparam logic [H_WIDTH-1:0] H_SYNC_FIRST = H_WIDTH'(H_ACTIVE + H_FRONT);
	localparam logic [H_WIDTH-1:0] H_SYNC_LAST = H_WIDTH'(H_ACTIVE + H_FRONT + H_SYNC - 1);
	localparam logic [H_WIDTH-1:0] H_LAST = H_WIDTH'(H_TOTAL - 1);
	localparam logic [V_WIDTH-1:0] V_LAST_ACTIVE = V_WIDTH'(V_ACTIVE - 1);
	localparam logic [V_WIDTH-1:0] V_SYNC_FIRST = V_WIDTH'(V_ACTIVE + V_FRONT);
	localparam logic [V_WIDTH-1:0] V_SYNC_LAST = V_WIDTH'(V_ACTIVE + V_FRONT + V_SYNC - 1);
	localparam logic [V_WIDTH-1:0] V_LAST = V_WIDTH'(V_TOTAL - 1);

	logic [H_WIDTH-1:0] h_count;
	logic [H_WIDTH-1:0] h_next;
	logic [V_WIDTH-1:0] v_count;
	logic [V_WIDTH-1:0] v_next;
	logic line_end;
	logic visible_next;
	logic h_sync_next;
	logic v_sync_next;

	// Pixel clock is clk divided by two
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			pixel_enable <= 1'b0;
		else
			pixel_enable <= !pixel_enable;
	end

	// Counter positions after the next pixel step
	always_comb
	begin
		line_end = h_count == H_LAST;
		h_next = line_end ? '0 : h_count + 1'b1;
		if (!line_end)
			v_next = v_count;
		else if (v_count == V_LAST)
			v_next = '0;
		else
			v_next = v_count + 1'b1;

		// Decode phases at the new position
		visible_next = h_next <= H_LAST_ACTIVE && v_next <= V_LAST_ACTIVE;
		h_sync_next = h_next >= H_SYNC_FIRST && h_next <= H_SYNC_LAST;
		v_sync_next = v_next >= V_SYNC_FIRST && v_next <= V_SYNC_LAST;
	end

	// Counters start on the last visible pixel
	// so the first frame start comes right after reset
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			h_count <= H_LAST_ACTIVE;
			v_count <= V_LAST_ACTIVE;
			in_visible_region <= 1'b0;
			vga_hs <= 1'b1;
			vga_vs <= 1'b1;
		end
		else if (pixel_enable)
		begin
			h_count <= h_next;
			v_count <= v_next;
			// Registered so the DAC pins change together
			in_visible_region <= visible_next;
			vga_hs <= !h_sync_next;
			vga_vs <= !v_sync_next;
		end
	end

	// Ends the last pixel of the last visible line
	assign new_frame = pixel_enable && h_count == H_LAST_ACTIVE && v_count == V_LAST_ACTIVE;

endmodule

`default_nettype wire

/* rtl/pixel_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module pixel_fifo
#(
	parameter int FIFO_DEPTH = 128,
	parameter int ALMOST_EMPTY_THRESHOLD = 63
)
(
	input wire clk,
	input wire reset,
	input wire flush_en,
	input wire enqueue_en,
	input wire vga_pkg::pixel_word_t value_i,
	input wire dequeue_en,
	output vga_pkg::pixel_word_t value_o,
	output logic empty,
	output logic almost_empty
);

	localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);
	localparam logic [PTR_WIDTH:0] FULL_COUNT = (PTR_WIDTH + 1)'(FIFO_DEPTH);
	localparam logic [PTR_WIDTH:0] LOW_COUNT = (PTR_WIDTH + 1)'(ALMOST_EMPTY_THRESHOLD);

	// Depth is a power of two so pointers wrap on their own
	logic [PTR_WIDTH-1:0] rd_ptr;
	logic [PTR_WIDTH-1:0] wr_ptr;
	// One bit wider than the pointers to tell full from empty
	logic [PTR_WIDTH:0] count;
	logic full;

	vga_pkg::pixel_word_t storage [FIFO_DEPTH];

	// Write port
	always_ff @(posedge clk)
	begin
		if (enqueue_en && !flush_en)
			storage[wr_ptr] <= value_i;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end
		else if (flush_en)
		begin
			// Drop everything, a word arriving now included
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (enqueue_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (dequeue_en)
				rd_ptr <= rd_ptr + 1'b1;

			// Occupancy only moves when one side is idle
			if (enqueue_en && !dequeue_en)
				count <= count + 1'b1;
			else if (dequeue_en && !enqueue_en)
				count <= count - 1'b1;
		end
	end

	// Head of queue, read without latency
	assign value_o = storage[rd_ptr];

	assign empty = count == '0;
	assign full = count == FULL_COUNT;
	// Enough room left for one whole burst
	assign almost_empty = count <= LOW_COUNT;

	// Refill is only started with room for a full burst
	overflow_check: assert property (@(posedge clk) disable iff (reset)
		enqueue_en && full && !flush_en |-> dequeue_en)
	else
		$error("pixel_fifo: enqueue while full");

endmodule

`default_nettype wire

/* rtl/fetch_address_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_address_unit
#(
	parameter int H_ACTIVE = 640,
	parameter int V_ACTIVE = 480,
	parameter int BURST_LENGTH = 64,
	parameter logic [vga_pkg::ADDR_WIDTH-1:0] DEFAULT_FB_BASE = 32'h0020_0000
)
(
	input wire clk,
	input wire reset,
	input wire fb_base_update_en,
	input wire [vga_pkg::ADDR_WIDTH-1:0] fb_new_base,
	input wire frame_start,
	input wire burst_done,
	output logic [vga_pkg::ADDR_WIDTH-1:0] burst_addr,
	output logic last_burst
);

	localparam int FRAME_PIXELS = H_ACTIVE * V_ACTIVE;
	localparam int COUNT_WIDTH = $clog2(FRAME_PIXELS + 1);

	// Bytes covered by one burst
	localparam logic [vga_pkg::ADDR_WIDTH-1:0] ADDR_STEP =
		vga_pkg::ADDR_WIDTH'(BURST_LENGTH * vga_pkg::BYTES_PER_PIXEL);
	localparam logic [COUNT_WIDTH-1:0] COUNT_STEP = COUNT_WIDTH'(BURST_LENGTH);
	// Pixels already fetched when the final burst is in flight
	localparam logic [COUNT_WIDTH-1:0] LAST_COUNT = COUNT_WIDTH'(FRAME_PIXELS - BURST_LENGTH);

	logic [vga_pkg::ADDR_WIDTH-1:0] pending_base;
	logic [COUNT_WIDTH-1:0] pixel_count;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			pending_base <= DEFAULT_FB_BASE;
			burst_addr <= DEFAULT_FB_BASE;
			pixel_count <= '0;
		end
		else
		begin
			// Host may replace the base at any time
			if (fb_base_update_en)
				pending_base <= fb_new_base;

			// Frame start sees the base held before this cycle
			if (frame_start)
			begin
				burst_addr <= pending_base;
				pixel_count <= '0;
			end
			else if (burst_done)
			begin
				burst_addr <= burst_addr + ADDR_STEP;
				pixel_count <= pixel_count + COUNT_STEP;
			end
		end
	end

	assign last_burst = pixel_count == LAST_COUNT;

endmodule

`default_nettype wire

/* rtl/frame_fetch_control.sv */
`timescale 1ns/10ps
`default_nettype none

module frame_fetch_control
#(
	parameter int BURST_LENGTH = 64
)
(
	input wire clk,
	input wire reset,
	input wire new_frame,
	input wire fifo_almost_empty,
	input wire last_burst,
	input wire mem_arready,
	input wire mem_rvalid,
	output logic mem_arvalid,
	output logic frame_start,
	output logic burst_done,
	output logic frame_toggle
);

	// FSM encoding
	localparam logic [1:0] STATE_WAIT_FRAME = 2'd0;
	localparam logic [1:0] STATE_WAIT_ROOM = 2'd1;
	localparam logic [1:0] STATE_ISSUE_ADDR = 2'd2;
	localparam logic [1:0] STATE_BURST_ACTIVE = 2'd3;

	// A single-beat burst still needs one counter bit
	localparam int BEAT_WIDTH = BURST_LENGTH > 1 ? $clog2(BURST_LENGTH) : 1;
	localparam logic [BEAT_WIDTH-1:0] LAST_BEAT = BEAT_WIDTH'(BURST_LENGTH - 1);

	logic [1:0] state;
	logic [1:0] state_next;
	logic [BEAT_WIDTH-1:0] beat_count;

	// Only a controller at rest picks up a new frame
	assign frame_start = state == STATE_WAIT_FRAME && new_frame;
	assign mem_arvalid = state == STATE_ISSUE_ADDR;
	// Final data beat of the current burst
	assign burst_done = state == STATE_BURST_ACTIVE && mem_rvalid && beat_count == LAST_BEAT;

	always_comb
	begin
		state_next = state;
		case (state)
			STATE_WAIT_FRAME:
			begin
				// FIFO is flushed on this same cycle, no room check needed
				if (new_frame)
					state_next = STATE_ISSUE_ADDR;
			end

			STATE_WAIT_ROOM:
			begin
				if (fifo_almost_empty)
					state_next = STATE_ISSUE_ADDR;
			end

			STATE_ISSUE_ADDR:
			begin
				if (mem_arready)
					state_next = STATE_BURST_ACTIVE;
			end

			default:
			begin
				if (burst_done)
				begin
					if (last_burst)
						state_next = STATE_WAIT_FRAME;
					else if (fifo_almost_empty)
						state_next = STATE_ISSUE_ADDR;
					else
						state_next = STATE_WAIT_ROOM;
				end
			end
		endcase
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= STATE_WAIT_FRAME;
			beat_count <= '0;
			frame_toggle <= 1'b0;
		end
		else
		begin
			state <= state_next;

			// Count data beats within the burst
			if (burst_done)
				beat_count <= '0;
			else if (state == STATE_BURST_ACTIVE && mem_rvalid)
				beat_count <= beat_count + 1'b1;

			if (frame_start)
				frame_toggle <= !frame_toggle;
		end
	end

endmodule

`default_nettype wire

/* rtl/vga_scanout.sv */
`timescale 1ns/10ps
`default_nettype none

module vga_scanout
#(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT = 16,
	parameter int H_SYNC = 96,
	parameter int H_BACK = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT = 10,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 33,
	parameter int BURST_LENGTH = 64,
	parameter int FIFO_DEPTH = 128,
	parameter logic [vga_pkg::ADDR_WIDTH-1:0] DEFAULT_FB_BASE = 32'h0020_0000
)
(
	input wire clk,
	input wire reset,

	// Host side
	input wire fb_base_update_en,
	input wire [vga_pkg::ADDR_WIDTH-1:0] fb_new_base,
	output logic frame_toggle,

	// Memory read port
	output logic [vga_pkg::ADDR_WIDTH-1:0] mem_araddr,
	output logic [7:0] mem_arlen,
	output logic mem_arvalid,
	input wire mem_arready,
	input wire [vga_pkg::MEM_DATA_WIDTH-1:0] mem_rdata,
	input wire mem_rvalid,
	output logic mem_rready,

	// Video DAC
	output logic [vga_pkg::COLOR_WIDTH-1:0] vga_r,
	output logic [vga_pkg::COLOR_WIDTH-1:0] vga_g,
	output logic [vga_pkg::COLOR_WIDTH-1:0] vga_b,
	output logic vga_clk,
	output logic vga_blank_n,
	output logic vga_hs,
	output logic vga_vs
);

	logic pixel_enable;
	logic in_visible_region;
	logic new_frame;
	logic fifo_empty;
	logic fifo_almost_empty;
	logic fifo_dequeue_en;
	logic frame_start;
	logic burst_done;
	logic last_burst;
	vga_pkg::pixel_word_t fifo_in;
	vga_pkg::pixel_word_t fifo_head;

	vga_timing_generator #(
		.H_ACTIVE(H_ACTIVE),
		.H_FRONT(H_FRONT),
		.H_SYNC(H_SYNC),
		.H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE),
		.V_FRONT(V_FRONT),
		.V_SYNC(V_SYNC),
		.V_BACK(V_BACK)
	) i_timing_generator (
		.clk(clk),
		.reset(reset),
		.pixel_enable(pixel_enable),
		.in_visible_region(in_visible_region),
		.new_frame(new_frame),
		.vga_hs(vga_hs),
		.vga_vs(vga_vs)
	);

	// Memory words go in raw
	assign fifo_in.raw = mem_rdata;

	// One pixel leaves per visible pixel period
	assign fifo_dequeue_en = pixel_enable && in_visible_region && !fifo_empty;

	// Flushed each frame so an underrun cannot shift later frames
	pixel_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH),
		.ALMOST_EMPTY_THRESHOLD(FIFO_DEPTH - BURST_LENGTH - 1)
	) i_pixel_fifo (
		.clk(clk),
		.reset(reset),
		.flush_en(new_frame),
		.enqueue_en(mem_rvalid),
		.value_i(fifo_in),
		.dequeue_en(fifo_dequeue_en),
		.value_o(fifo_head),
		.empty(fifo_empty),
		.almost_empty(fifo_almost_empty)
	);

	fetch_address_unit #(
		.H_ACTIVE(H_ACTIVE),
		.V_ACTIVE(V_ACTIVE),
		.BURST_LENGTH(BURST_LENGTH),
		.DEFAULT_FB_BASE(DEFAULT_FB_BASE)
	) i_fetch_address_unit (
		.clk(clk),
		.reset(reset),
		.fb_base_update_en(fb_base_update_en),
		.fb_new_base(fb_new_base),
		.frame_start(frame_start),
		.burst_done(burst_done),
		.burst_addr(mem_araddr),
		.last_burst(last_burst)
	);

	frame_fetch_control #(
		.BURST_LENGTH(BURST_LENGTH)
	) i_frame_fetch_control (
		.clk(clk),
		.reset(reset),
		.new_frame(new_frame),
		.fifo_almost_empty(fifo_almost_empty),
		.last_burst(last_burst),
		.mem_arready(mem_arready),
		.mem_rvalid(mem_rvalid),
		.mem_arvalid(mem_arvalid),
		.frame_start(frame_start),
		.burst_done(burst_done),
		.frame_toggle(frame_toggle)
	);

	// Fixed burst size on every request
	assign mem_arlen = 8'(BURST_LENGTH - 1);
	// FIFO always has room for a burst it asked for
	assign mem_rready = 1'b1;

	// Colour channels from the head word
	assign vga_r = fifo_head.color.r;
	assign vga_g = fifo_head.color.g;
	assign vga_b = fifo_head.color.b;

	// Pixel strobe doubles as the DAC clock
	assign vga_clk = pixel_enable;
	assign vga_blank_n = in_visible_region;

	// Fetch must keep ahead of the display during visible time
	underrun_check: assert property (@(posedge clk) disable iff (reset)
		pixel_enable && in_visible_region |-> !fifo_empty)
	else
		$error("vga_scanout: pixel FIFO underrun");

endmodule

`default_nettype wire

/* verif/memory_read_model.sv */
`timescale 1ns/10ps
`default_nettype none

module memory_read_model
#(
	parameter logic [31:0] DATA_MASK = 32'h5A3C_96E1,
	parameter logic [31:0] SEED = 32'd82243
)
(
	input wire clk,
	input wire reset,
	input wire [vga_pkg::ADDR_WIDTH-1:0] araddr,
	input wire [7:0] arlen,
	input wire arvalid,
	output logic arready,
	output logic [vga_pkg::MEM_DATA_WIDTH-1:0] rdata,
	output logic rvalid
);

	// Byte step from one word to the next
	localparam int WORD_BYTES = 4;

	logic [31:0] rng_state;
	// Addresses of the data beats still owed, oldest first
	logic [vga_pkg::ADDR_WIDTH-1:0] beat_addr [$];
	// Previous beat slot was skipped
	logic stalled;

	// Linear congruential generator, upper bits are the useful ones
	function automatic logic [31:0] next_random();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	always @(posedge clk, posedge reset)
	begin
		logic [31:0] draw;
		if (reset)
		begin
			rng_state = SEED;
			beat_addr.delete();
			stalled <= 1'b0;
			arready <= 1'b0;
			rvalid <= 1'b0;
			rdata <= '0;
		end
		else
		begin
			// Burst accepted on this edge
			// all its beats queue up in address order
			if (arvalid && arready)
			begin
				for (int i = 0; i <= int'(arlen); i++)
					beat_addr.push_back(araddr + vga_pkg::ADDR_WIDTH'(i * WORD_BYTES));
			end

			draw = next_random();
			// Ready three cycles in four
			arready <= draw[31:30] != 2'b00;

			// A beat waits one cycle at most
			if (beat_addr.size() != 0 && (stalled || draw[29]))
			begin
				// Word content follows from its own address
				rdata <= beat_addr.pop_front() ^ DATA_MASK;
				rvalid <= 1'b1;
				stalled <= 1'b0;
			end
			else
			begin
				rvalid <= 1'b0;
				stalled <= beat_addr.size() != 0;
			end
		end
	end

endmodule

`default_nettype wire

/* verif/vga_scanout_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module vga_scanout_tb;

	// Tiny screen so that several frames fit in one run
	localparam int H_ACTIVE = 16;
	localparam int H_FRONT = 2;
	localparam int H_SYNC = 3;
	localparam int H_BACK = 3;
	localparam int V_ACTIVE = 6;
	localparam int V_FRONT = 1;
	localparam int V_SYNC = 1;
	localparam int V_BACK = 2;
	localparam int BURST_LENGTH = 8;
	localparam int FIFO_DEPTH = 16;
	localparam logic [31:0] DEFAULT_FB_BASE = 32'h0010_0000;
	localparam logic [31:0] DATA_MASK = 32'h5A3C_96E1;
	localparam logic [31:0] SEED = 32'd82243;

	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	// Two clocks per pixel period
	localparam int FRAME_CLOCKS = 2 * H_TOTAL * V_TOTAL;
	localparam int BURSTS_PER_FRAME = H_ACTIVE * V_ACTIVE / BURST_LENGTH;
	localparam int BURST_BYTES = BURST_LENGTH * 4;
	localparam int RESET_CYCLES = 16;
	localparam int TEST_FRAMES = 6;
	// Partial first frame included
	// Half again as margin
	localparam int TIMEOUT_CYCLES = (RESET_CYCLES + (TEST_FRAMES + 1) * FRAME_CLOCKS) * 3 / 2;

	logic clk;
	logic reset;
	logic fb_base_update_en;
	logic [31:0] fb_new_base;
	logic frame_toggle;
	logic [31:0] mem_araddr;
	logic [7:0] mem_arlen;
	logic mem_arvalid;
	logic mem_arready;
	logic [31:0] mem_rdata;
	logic mem_rvalid;
	logic mem_rready;
	logic [7:0] vga_r;
	logic [7:0] vga_g;
	logic [7:0] vga_b;
	logic vga_clk;
	logic vga_blank_n;
	logic vga_hs;
	logic vga_vs;

	// Reference model state
	logic [31:0] rng_state;
	// Base held by the DUT in this cycle and in the one before
	logic [31:0] pending_base;
	logic [31:0] prev_pending_base;
	// Base of the frame being fetched and shown
	logic [31:0] frame_base;
	int h_pos;
	int v_pos;
	logic synced;
	logic last_toggle;
	// Pixel strobe level due in this cycle
	logic clk_phase;
	// Next cycle is the frame-start cycle
	logic update_at_frame_edge;
	int burst_index;
	int visible_count;
	int hs_low_count;
	int vs_low_count;
	int frames_done;
	int frame_errors;
	int check_count;
	int error_count;
	int cycle_count;

	vga_scanout #(
		.H_ACTIVE(H_ACTIVE),
		.H_FRONT(H_FRONT),
		.H_SYNC(H_SYNC),
		.H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE),
		.V_FRONT(V_FRONT),
		.V_SYNC(V_SYNC),
		.V_BACK(V_BACK),
		.BURST_LENGTH(BURST_LENGTH),
		.FIFO_DEPTH(FIFO_DEPTH),
		.DEFAULT_FB_BASE(DEFAULT_FB_BASE)
	) i_vga_scanout (
		.clk(clk),
		.reset(reset),
		.fb_base_update_en(fb_base_update_en),
		.fb_new_base(fb_new_base),
		.frame_toggle(frame_toggle),
		.mem_araddr(mem_araddr),
		.mem_arlen(mem_arlen),
		.mem_arvalid(mem_arvalid),
		.mem_arready(mem_arready),
		.mem_rdata(mem_rdata),
		.mem_rvalid(mem_rvalid),
		.mem_rready(mem_rready),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b),
		.vga_clk(vga_clk),
		.vga_blank_n(vga_blank_n),
		.vga_hs(vga_hs),
		.vga_vs(vga_vs)
	);

	memory_read_model #(
		.DATA_MASK(DATA_MASK),
		.SEED(SEED)
	) i_memory_read_model (
		.clk(clk),
		.reset(reset),
		.araddr(mem_araddr),
		.arlen(mem_arlen),
		.arvalid(mem_arvalid),
		.arready(mem_arready),
		.rdata(mem_rdata),
		.rvalid(mem_rvalid)
	);

	// Linear congruential generator for the host stimulus
	function automatic logic [31:0] next_random();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state;
	endfunction

	task automatic fail_check(input string text);
		$display("%s", text);
		error_count++;
		frame_errors++;
	endtask

	// One DUT output against its model value
	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		check_count++;
		assert (actual === expected)
		else
			fail_check($sformatf("ERROR %s: got 0x%0h, expected 0x%0h at %0t",
				name, actual, expected, $time));
	endtask

	// Per-frame totals
	task automatic check_total(input string what, input int actual, input int expected);
		check_count++;
		assert (actual == expected)
		else
			fail_check($sformatf("Frame %0d had %0d %s instead of %0d",
				frames_done, actual, what, expected));
	endtask

	// DAC pins against the counted screen position
	task automatic check_position();
		logic visible;
		logic hs_expected;
		logic vs_expected;
		logic [31:0] word;
		visible = h_pos < H_ACTIVE && v_pos < V_ACTIVE;
		hs_expected = !(h_pos >= H_ACTIVE + H_FRONT && h_pos < H_ACTIVE + H_FRONT + H_SYNC);
		vs_expected = !(v_pos >= V_ACTIVE + V_FRONT && v_pos < V_ACTIVE + V_FRONT + V_SYNC);
		check_value("vga_blank_n", 32'(vga_blank_n), 32'(visible));
		check_value("vga_hs", 32'(vga_hs), 32'(hs_expected));
		check_value("vga_vs", 32'(vga_vs), 32'(vs_expected));
		// A pixel period is counted on its vga_clk high cycle
		if (vga_clk)
		begin
			if (vga_blank_n)
				visible_count++;
			if (!vga_hs)
				hs_low_count++;
			if (!vga_vs)
				vs_low_count++;
			if (visible)
			begin
				// Row-major framebuffer with one word per pixel
				word = (frame_base + 32'(4 * (v_pos * H_ACTIVE + h_pos))) ^ DATA_MASK;
				check_value("vga_r", 32'(vga_r), 32'(word[31:24]));
				check_value("vga_g", 32'(vga_g), 32'(word[23:16]));
				check_value("vga_b", 32'(vga_b), 32'(word[15:8]));
			end
		end
	endtask

	// Toggle seen one cycle after the last visible line ended
	task automatic start_frame();
		if (synced)
		begin
			check_count++;
			assert (h_pos == H_ACTIVE && v_pos == V_ACTIVE - 1 && !vga_clk)
			else
				fail_check($sformatf("frame_toggle flipped at pixel %0d of line %0d",
					h_pos, v_pos));
			check_total("visible pixels", visible_count, H_ACTIVE * V_ACTIVE);
			check_total("hsync pixel periods", hs_low_count, H_SYNC * V_TOTAL);
			check_total("vsync pixel periods", vs_low_count, V_SYNC * H_TOTAL);
			check_total("bursts", burst_index, BURSTS_PER_FRAME);
			$display("Frame %0d: base 0x%h, %0d pixels, %0d bursts, %0d errors",
				frames_done, frame_base, visible_count, burst_index, frame_errors);
			frames_done++;
		end
		// Base held before the frame-start cycle
		frame_base = prev_pending_base;
		h_pos = H_ACTIVE;
		v_pos = V_ACTIVE - 1;
		synced = 1'b1;
		burst_index = 0;
		visible_count = 0;
		hs_low_count = 0;
		vs_low_count = 0;
		frame_errors = 0;
		// First address of the frame is out right away
		check_value("mem_arvalid", 32'(mem_arvalid), 32'd1);
		check_value("mem_araddr", mem_araddr, frame_base);
		check_value("mem_rready", 32'(mem_rready), 32'd1);
	endtask

	// Each accepted address is one burst further into the frame
	task automatic check_burst();
		check_value("mem_arlen", 32'(mem_arlen), 32'(BURST_LENGTH - 1));
		check_value("mem_araddr", mem_araddr, frame_base + 32'(burst_index * BURST_BYTES));
		burst_index++;
	endtask

	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = !clk;
	end

	initial
	begin
		rng_state = SEED;
		reset = 1'b1;
		fb_base_update_en = 1'b0;
		fb_new_base = '0;
		update_at_frame_edge = 1'b0;
		frames_done = 0;
		check_count = 0;
		error_count = 0;
		repeat (RESET_CYCLES)
			@(posedge clk);
		reset <= 1'b0;
		wait (frames_done == TEST_FRAMES);
		@(posedge clk);
		$display("Frames %0d, checks %0d, errors %0d", frames_done, check_count, error_count);
		if (error_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// Run limit
	initial
	begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, only %0d of %0d frames checked",
			cycle_count, frames_done, TEST_FRAMES);
		$display("RESULT: FAIL");
		$finish;
	end

	// Host writes 64-byte aligned bases at random times
	always @(posedge clk)
	begin
		logic [31:0] draw;
		if (!reset)
		begin
			draw = next_random();
			// Every other frame also gets a write in the frame-start cycle
			if ((update_at_frame_edge && frames_done % 2 == 1) || draw[31:26] == 6'd0)
			begin
				fb_base_update_en <= 1'b1;
				fb_new_base <= 32'h1000_0000 | (next_random() & 32'h00FF_FFC0);
			end
			else
				fb_base_update_en <= 1'b0;
		end
	end

	// Monitor samples mid-cycle
	always @(negedge clk)
	begin
		if (reset)
		begin
			check_value("mem_arvalid", 32'(mem_arvalid), 32'd0);
			check_value("frame_toggle", 32'(frame_toggle), 32'd0);
			check_value("vga_blank_n", 32'(vga_blank_n), 32'd0);
			check_value("vga_hs", 32'(vga_hs), 32'd1);
			check_value("vga_vs", 32'(vga_vs), 32'd1);
			check_value("vga_clk", 32'(vga_clk), 32'd0);
			synced = 1'b0;
			last_toggle = 1'b0;
			clk_phase = 1'b0;
			pending_base = DEFAULT_FB_BASE;
			prev_pending_base = DEFAULT_FB_BASE;
		end
		else
		begin
			// Strobe is low first after reset, then flips every clock
			check_value("vga_clk", 32'(vga_clk), 32'(clk_phase));
			clk_phase = !clk_phase;

			if (frame_toggle != last_toggle)
				start_frame();
			if (synced)
				check_position();
			if (synced && mem_arvalid && mem_arready)
				check_burst();

			// Position moves on after each vga_clk high cycle
			if (synced && vga_clk)
			begin
				if (h_pos == H_TOTAL - 1)
				begin
					h_pos = 0;
					v_pos = v_pos == V_TOTAL - 1 ? 0 : v_pos + 1;
				end
				else
					h_pos++;
			end
			update_at_frame_edge = synced && !vga_clk && h_pos == H_ACTIVE - 1
				&& v_pos == V_ACTIVE - 1;

			// A write in this cycle is held from the next one
			prev_pending_base = pending_base;
			if (fb_base_update_en)
				pending_base = fb_new_base;
			last_toggle = frame_toggle;
		end
	end

endmodule

`default_nettype wire

/* vga_scanout.f */
rtl/vga_pkg.sv
rtl/vga_timing_generator.sv
rtl/pixel_fifo.sv
rtl/fetch_address_unit.sv
rtl/frame_fetch_control.sv
rtl/vga_scanout.sv
verif/memory_read_model.sv
verif/vga_scanout_tb.sv

/* Makefile */
# Verilator build and run of the scanout testbench
TOP = vga_scanout_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f vga_scanout.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
